// File: flist.f
logic/memUnitPkg.sv
logic/memCfgIf.sv
logic/memPortIf.sv
logic/cfgRegs.sv
logic/addrGen.sv
logic/dpRam.sv
logic/dataMem.sv
logic/memUnitTop.sv
test/memUnit_assertions.sv
test/memUnitTb.sv

// File: Bender.yml
package:
  name: mem_unit

sources:
  - logic/memUnitPkg.sv
  - logic/memCfgIf.sv
  - logic/memPortIf.sv
  - logic/cfgRegs.sv
  - logic/addrGen.sv
  - logic/dpRam.sv
  - logic/dataMem.sv
  - logic/memUnitTop.sv
  - target: test
    files:
      - test/memUnit_assertions.sv
      - test/memUnitTb.sv

// File: test/memUnitTb.sv
`default_nettype none

module memUnitTb import memUnitPkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int Depth = 1 << AddrW;
   localparam int MaxIter = 4;
   localparam int MaxIter2 = 3;
   localparam int MaxPer = 8;
   localparam int MaxSteps = MaxIter * MaxIter2 * MaxPer;
   localparam int NumRuns = 21;
   localparam int WriteRuns = 5;
   localparam int RunCycles = 2 * CfgFields + (1 << PeriodW) + MaxSteps + 8;
   localparam int HostOps = Depth + 64 + WriteRuns * MaxSteps + 32;
   localparam int TimeoutCycles = 2 * (16 + 4 * HostOps + NumRuns * RunCycles);

   localparam int ModeRead = 0;
   localparam int ModeWrite = 1;
   localparam int ModeReverse = 2;
   localparam int ModeExt = 3;
   localparam int ModeIdle = 4;
   localparam int ModeNoIter = 5;

   logic      clk = 1'b0;
   logic      rst;
   logic      run;
   logic      done;
   logic      valid;
   logic [3:0] wstrb;
   addr_t     addr;
   data_t     wdata;
   logic      ready;
   data_t     rdata;
   logic      cfgWrite;
   logic      cfgPort;
   cfgField_t cfgField;
   addr_t     cfgData;
   data_t     in0;
   data_t     in1;
   data_t     out0;
   data_t     out1;

   // reference state
   data_t     model [int];
   int        cfg [2][CfgFields];
   int        written [$];

   memUnitTop #(.addrW(AddrW), .dataW(DataW)) u_dut (
      .clk(clk), .rst(rst), .run(run), .done(done),
      .valid(valid), .wstrb(wstrb), .addr(addr), .wdata(wdata),
      .ready(ready), .rdata(rdata),
      .cfgWrite(cfgWrite), .cfgPort(cfgPort), .cfgField(cfgField), .cfgData(cfgData),
      .in0(in0), .in1(in1), .out0(out0), .out1(out1)
   );

   always #5 clk = ~clk;

   task automatic stopFailed();
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic valueError(string msg);
      $display("[ERROR] %0.1f ns: %s", $realtime, msg);
      stopFailed();
   endtask

   // one clock, inputs change 1 ns after the edge
   task automatic tick();
      @(posedge clk);
      #1;
      if (u_dut.chk.failCount != 0) begin
         $display("a bound assertion on the host bus or done failed");
         stopFailed();
      end
   endtask

   function automatic int flipAddr(int a);
      int r;
      r = 0;
      for (int b = 0; b < AddrW; b++) begin
         r = (r << 1) | ((a >> b) & 1);
      end
      return r;
   endfunction

   function automatic int stepCount(int p);
      if (cfg[p][fldIter] == 0 || cfg[p][fldIter2] == 0 || cfg[p][fldPer] == 0) begin
         return 0;
      end
      return cfg[p][fldIter] * cfg[p][fldIter2] * cfg[p][fldPer];
   endfunction

   // address of step s, decomposed into (j, i, k)
   function automatic int stepAddr(int p, int s, data_t din);
      int per;
      int k;
      int i;
      int j;
      int a;
      per = cfg[p][fldPer];
      k = s % per;
      i = (s / per) % cfg[p][fldIter];
      j = s / (per * cfg[p][fldIter]);
      a = (cfg[p][fldStart] + j * cfg[p][fldShift2] + i * cfg[p][fldShift]
           + k * cfg[p][fldIncr]) % Depth;
      if (cfg[p][fldExt] != 0) begin
         return int'(din[AddrW-1:0]);
      end
      return (cfg[p][fldReverse] != 0) ? flipAddr(a) : a;
   endfunction

   task automatic hostAccess(logic wr, int a, data_t d);
      int lat;
      valid = 1'b1;
      wstrb = wr ? 4'($urandom_range(15, 1)) : 4'd0;
      addr = addr_t'(a);
      wdata = d;
      tick();
      valid = 1'b0;
      wstrb = 4'd0;
      lat = 1;
      while (!ready && lat < 8) begin
         tick();
         lat++;
      end
      assert (lat == 3)
         else valueError($sformatf("ready came %0d cycles after valid, expected 3", lat));
      if (wr) begin
         model[a] = d;
      end else begin
         assert (rdata === model[a])
            else valueError($sformatf("host read of %0d gave %h, expected %h",
                                      a, rdata, model[a]));
      end
      tick();
   endtask

   task automatic writeField(int p, int f);
      cfgWrite = 1'b1;
      cfgPort = p[0];
      cfgField = cfgField_t'(f);
      cfgData = addr_t'(cfg[p][f]);
      tick();
      cfgWrite = 1'b0;
   endtask

   task automatic pickConfig(int p, int mode);
      int per;
      per = $urandom_range(MaxPer, 1);
      cfg[p][fldIter] = $urandom_range(MaxIter, 1);
      cfg[p][fldPer] = per;
      cfg[p][fldDuty] = $urandom_range(per, 0);
      cfg[p][fldStart] = $urandom_range(Depth - 1, 0);
      cfg[p][fldShift] = $urandom_range(Depth - 1, 0);
      cfg[p][fldIncr] = $urandom_range(Depth - 1, 0);
      cfg[p][fldDelay] = $urandom_range((1 << PeriodW) - 1, 0);
      cfg[p][fldReverse] = (mode == ModeReverse);
      cfg[p][fldExt] = (mode == ModeExt);
      cfg[p][fldWrEn] = (mode == ModeWrite);
      cfg[p][fldIter2] = $urandom_range(MaxIter2, 1);
      cfg[p][fldShift2] = $urandom_range(Depth - 1, 0);
      if (mode == ModeNoIter) begin
         // full duty with writes on, so any stray step would show
         cfg[p][fldIter] = 0;
         cfg[p][fldDuty] = per;
         cfg[p][fldWrEn] = 1;
      end
      if (mode == ModeIdle) begin
         for (int f = 0; f < CfgFields; f++) begin
            cfg[p][f] = 0;
         end
      end
   endtask

   // strobe run and follow both generators cycle by cycle
   task automatic doRun();
      int    steps [2];
      int    last [2];
      int    endOff;
      int    s;
      int    a;
      logic  expDone;
      data_t din;
      data_t hold0;
      int    chkCyc [$];
      int    chkPort [$];
      data_t chkVal [$];
      for (int p = 0; p < 2; p++) begin
         steps[p] = stepCount(p);
         // a zero-length loop still spends one step cycle
         last[p] = cfg[p][fldDelay] + ((steps[p] == 0) ? 1 : steps[p]);
      end
      endOff = (last[0] > last[1]) ? last[0] : last[1];
      hold0 = out0;
      run = 1'b1;
      for (int o = 0; o <= endOff + 4; o++) begin
         in0 = $urandom();
         in1 = $urandom();
         expDone = (o == 0) || (o > endOff);
         assert (done === expDone)
            else valueError($sformatf("done is %b in run cycle %0d, expected %b",
                                      done, o, expDone));
         if (steps[0] == 0) begin
            assert (out0 === hold0)
               else valueError("out0 changed during a run without enables");
         end
         while (chkCyc.size() > 0 && chkCyc[0] == o) begin
            din = (chkPort[0] != 0) ? out1 : out0;
            assert (din === chkVal[0])
               else valueError($sformatf("out%0d is %h in run cycle %0d, expected %h",
                                         chkPort[0], din, o, chkVal[0]));
            void'(chkCyc.pop_front());
            void'(chkPort.pop_front());
            void'(chkVal.pop_front());
         end
         for (int p = 0; p < 2; p++) begin
            s = o - 1 - cfg[p][fldDelay];
            if (s >= 0 && s < steps[p] && (s % cfg[p][fldPer]) < cfg[p][fldDuty]) begin
               din = (p != 0) ? in1 : in0;
               a = stepAddr(p, s, din);
               if (cfg[p][fldWrEn] != 0 && cfg[p][fldExt] == 0) begin
                  model[a] = din;
                  written.push_back(a);
               end else begin
                  chkCyc.push_back(o + 3);
                  chkPort.push_back(p);
                  chkVal.push_back(model[a]);
               end
            end
         end
         tick();
         run = 1'b0;
      end
   endtask

   task automatic runWith(int modeA, int modeB);
      pickConfig(0, modeA);
      pickConfig(1, modeB);
      for (int p = 0; p < 2; p++) begin
         for (int f = 0; f < CfgFields; f++) begin
            writeField(p, f);
         end
      end
      doRun();
   endtask

   task automatic readBack();
      foreach (written[n]) begin
         hostAccess(1'b0, written[n], '0);
      end
      written.delete();
   endtask

   initial begin
      repeat (TimeoutCycles) @(posedge clk);
      $display("watchdog expired before the tests finished");
      stopFailed();
   end

   initial begin
      void'($urandom(32'hbe29ae9b));
      rst = 1'b1;
      run = 1'b0;
      valid = 1'b0;
      wstrb = 4'd0;
      addr = '0;
      wdata = '0;
      cfgWrite = 1'b0;
      cfgPort = 1'b0;
      cfgField = '0;
      cfgData = '0;
      in0 = '0;
      in1 = '0;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      assert (!ready && done && out0 == '0 && out1 == '0)
         else valueError("outputs are not at their reset values");

      // preload every word, then random host traffic
      for (int n = 0; n < Depth; n++) begin
         hostAccess(1'b1, n, $urandom());
      end
      repeat (64) hostAccess(1'($urandom_range(1, 0)), $urandom_range(Depth - 1, 0), $urandom());

      repeat (6) runWith(ModeRead, ModeIdle);
      repeat (4) begin
         runWith(ModeIdle, ModeWrite);
         readBack();
      end
      repeat (3) runWith(ModeReverse, ModeIdle);
      repeat (3) runWith(ModeExt, ModeIdle);

      // port B streaming out on out1
      repeat (3) runWith(ModeIdle, ModeRead);

      // both ports busy with different lengths
      runWith(ModeRead, ModeWrite);
      readBack();
      runWith(ModeNoIter, ModeIdle);
      hostAccess(1'b0, cfg[0][fldStart], '0);
      repeat (32) hostAccess(1'b0, $urandom_range(Depth - 1, 0), '0);

      if (u_dut.chk.failCount == 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("a bound assertion failed near the end of the run");
         stopFailed();
      end
   end

endmodule

`default_nettype wire

// File: test/memUnit_assertions.sv
`default_nettype none

module memUnit_assertions import memUnitPkg::*; (
   input logic  clk,
   input logic  rst,
   input logic  valid,
   input logic  ready,
   input logic  done,
   input data_t rdata
);
   timeunit 1ns;
   timeprecision 100ps;

   int failCount = 0;

   // single-cycle ready
   assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
      else begin
         $error("ready stayed high for more than one cycle");
         failCount++;
      end

   assert property (@(posedge clk) disable iff (rst) valid |-> ##3 ready)
      else begin
         $error("ready missing three cycles after valid");
         failCount++;
      end

   assert property (@(posedge clk) disable iff (rst) ready |-> $past(valid, 3))
      else begin
         $error("ready without valid three cycles earlier");
         failCount++;
      end

   assert property (@(posedge clk) disable iff (rst) !ready |-> rdata == '0)
      else begin
         $error("rdata nonzero while ready is low");
         failCount++;
      end

   assert property (@(posedge clk) $fell(rst) |-> done)
      else begin
         $error("done low right after reset release");
         failCount++;
      end

endmodule

bind memUnitTop memUnit_assertions chk (
   .clk(clk),
   .rst(rst),
   .valid(valid),
   .ready(ready),
   .done(done),
   .rdata(rdata)
);

`default_nettype wire

// File: logic/memUnitTop.sv
`default_nettype none

module memUnitTop import memUnitPkg::*; #(
   parameter int addrW = 10,
   parameter int dataW = 32
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   output logic      done,

   // host bus
   input  logic      valid,
   input  logic [3:0] wstrb,
   input  addr_t     addr,
   input  data_t     wdata,
   output logic      ready,
   output data_t     rdata,

   // configuration writes
   input  logic      cfgWrite,
   input  logic      cfgPort,
   input  cfgField_t cfgField,
   input  addr_t     cfgData,

   // datapath
   input  data_t     in0,
   input  data_t     in1,
   output data_t     out0,
   output data_t     out1
);

   memCfgIf cfgA ();
   memCfgIf cfgB ();

   cfgRegs #(.addrW(addrW)) cfg (
      .clk(clk),
      .rst(rst),
      .run(run),
      .cfgWrite(cfgWrite),
      .cfgPort(cfgPort),
      .cfgField(cfgField),
      .cfgData(cfgData),
      .cfgA(cfgA.source),
      .cfgB(cfgB.source)
   );

   dataMem #(.addrW(addrW), .dataW(dataW)) mem (
      .clk(clk),
      .rst(rst),
      .run(run),
      .done(done),
      .valid(valid),
      .wstrb(wstrb),
      .addr(addr),
      .wdata(wdata),
      .ready(ready),
      .rdata(rdata),
      .in0(in0),
      .in1(in1),
      .out0(out0),
      .out1(out1),
      .cfgA(cfgA.sink),
      .cfgB(cfgB.sink)
   );

endmodule

`default_nettype wire

// File: logic/dataMem.sv
`default_nettype none

module dataMem import memUnitPkg::*; #(
   parameter int addrW = 10,
   parameter int dataW = 32
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   output logic               done,
   input  logic               valid,
   input  logic [dataW/8-1:0] wstrb,
   input  addr_t              addr,
   input  data_t              wdata,
   output logic               ready,
   output data_t              rdata,
   input  data_t              in0,
   input  data_t              in1,
   output data_t              out0,
   output data_t              out1,
   memCfgIf.sink              cfgA,
   memCfgIf.sink              cfgB
);

   memPortIf #(.addrW(addrW), .dataW(dataW)) portA ();
   memPortIf #(.addrW(addrW), .dataW(dataW)) portB ();

   addr_t            genAddrA;
   addr_t            genAddrB;
   logic             genEnA;
   logic             genEnB;
   logic             genDoneA;
   logic             genDoneB;
   logic [addrW-1:0] nextAddrA;
   logic [addrW-1:0] nextAddrB;
   logic             nextWeA;
   logic             nextWeB;
   data_t            outA;
   data_t            outB;
   logic [2:0]       validPipe;

   function automatic logic [addrW-1:0] reverseBits(logic [addrW-1:0] w);
      logic [addrW-1:0] r;
      for (int b = 0; b < addrW; b++) begin
         r[b] = w[addrW-1-b];
      end
      return r;
   endfunction

   addrGen genA (
      .clk(clk), .rst(rst), .run(run),
      .iter(cfgA.iter), .per(cfgA.per), .duty(cfgA.duty),
      .start(cfgA.start), .shift(cfgA.shift), .incr(cfgA.incr),
      .delay(cfgA.delay), .iter2(cfgA.iter2), .shift2(cfgA.shift2),
      .addr(genAddrA), .en(genEnA), .done(genDoneA)
   );

   addrGen genB (
      .clk(clk), .rst(rst), .run(run),
      .iter(cfgB.iter), .per(cfgB.per), .duty(cfgB.duty),
      .start(cfgB.start), .shift(cfgB.shift), .incr(cfgB.incr),
      .delay(cfgB.delay), .iter2(cfgB.iter2), .shift2(cfgB.shift2),
      .addr(genAddrB), .en(genEnB), .done(genDoneB)
   );

   // host first on port A, then external address, then generator
   assign nextAddrA = valid ? addr :
                      cfgA.ext ? in0[addrW-1:0] :
                      cfgA.reverse ? reverseBits(genAddrA) : genAddrA;
   assign nextAddrB = cfgB.ext ? in1[addrW-1:0] :
                      cfgB.reverse ? reverseBits(genAddrB) : genAddrB;

   // no writes while the input feeds the address
   assign nextWeA = valid ? |wstrb : (genEnA & cfgA.wrEn & ~cfgA.ext);
   assign nextWeB = genEnB & cfgB.wrEn & ~cfgB.ext;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         portA.en  <= 1'b0;
         portA.we  <= 1'b0;
         portB.en  <= 1'b0;
         portB.we  <= 1'b0;
         validPipe <= '0;
         outA      <= '0;
         outB      <= '0;
      end else begin
         portA.en  <= genEnA | valid;
         portA.we  <= nextWeA;
         portB.en  <= genEnB;
         portB.we  <= nextWeB;
         validPipe <= {validPipe[1:0], valid};
         outA      <= portA.rdata;
         outB      <= portB.rdata;
      end
   end

   always_ff @(posedge clk) begin
      portA.addr  <= nextAddrA;
      portA.wdata <= valid ? wdata : in0;
      portB.addr  <= nextAddrB;
      portB.wdata <= in1;
   end

   dpRam #(.addrW(addrW), .dataW(dataW)) ram (
      .clk(clk),
      .portA(portA.ram),
      .portB(portB.ram)
   );

   // ready lines up with the registered RAM output
   assign ready = validPipe[2];
   assign rdata = ready ? outA : '0;
   assign out0  = outA;
   assign out1  = outB;
   assign done  = genDoneA & genDoneB;

endmodule

`default_nettype wire

// File: logic/dpRam.sv
`default_nettype none

module dpRam #(
   parameter int addrW = 10,
   parameter int dataW = 32
) (
   input  logic   clk,
   memPortIf.ram  portA,
   memPortIf.ram  portB
);

   localparam int Depth = 1 << addrW;

   logic [dataW-1:0] mem [Depth];

   // read returns the old word when the same port writes
   always @(posedge clk) begin
      if (portA.en) begin
         if (portA.we) begin
            mem[portA.addr] <= portA.wdata;
         end
         portA.rdata <= mem[portA.addr];
      end
   end

   always @(posedge clk) begin
      if (portB.en) begin
         if (portB.we) begin
            mem[portB.addr] <= portB.wdata;
         end
         portB.rdata <= mem[portB.addr];
      end
   end

endmodule

`default_nettype wire

// File: logic/addrGen.sv
`default_nettype none

module addrGen import memUnitPkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    run,
   input  addr_t   iter,
   input  period_t per,
   input  period_t duty,
   input  addr_t   start,
   input  addr_t   shift,
   input  addr_t   incr,
   input  period_t delay,
   input  addr_t   iter2,
   input  addr_t   shift2,
   output addr_t   addr,
   output logic    en,
   output logic    done
);

   genState_t state;
   period_t   dlyCnt;

   // loop indices, k inside a period, i inner, j outer
   period_t   k;
   addr_t     i;
   addr_t     j;

   // running partial sums of the address terms
   addr_t     kOff;
   addr_t     iOff;
   addr_t     jOff;

   logic      stepping;
   logic      zeroLen;
   logic      lastK;
   logic      lastI;
   logic      lastJ;

   // config becomes active on the run edge, so the delay compare happens
   // live and a zero delay steps right in the first cycle after run
   assign stepping = (state == stRun) || (state == stDelay && dlyCnt == delay);
   assign zeroLen  = (iter == '0) || (iter2 == '0) || (per == '0);

   assign lastK = (period_t'(k + 1'b1) == per);
   assign lastI = (addr_t'(i + 1'b1) == iter);
   assign lastJ = (addr_t'(j + 1'b1) == iter2);

   assign addr = start + jOff + iOff + kOff;
   assign en   = stepping && !zeroLen && (k < duty);
   assign done = (state == stIdle);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state  <= stIdle;
         dlyCnt <= '0;
         k      <= '0;
         i      <= '0;
         j      <= '0;
         kOff   <= '0;
         iOff   <= '0;
         jOff   <= '0;
      end else if (run) begin
         state  <= stDelay;
         dlyCnt <= '0;
         k      <= '0;
         i      <= '0;
         j      <= '0;
         kOff   <= '0;
         iOff   <= '0;
         jOff   <= '0;
      end else if (stepping) begin
         if (zeroLen || (lastK && lastI && lastJ)) begin
            state <= stIdle;
         end else begin
            state <= stRun;
            if (!lastK) begin
               k    <= k + 1'b1;
               kOff <= kOff + incr;
            end else begin
               k    <= '0;
               kOff <= '0;
               if (!lastI) begin
                  i    <= i + 1'b1;
                  iOff <= iOff + shift;
               end else begin
                  // wrap inner loop, next outer iteration
                  i    <= '0;
                  iOff <= '0;
                  j    <= j + 1'b1;
                  jOff <= jOff + shift2;
               end
            end
         end
      end else if (state == stDelay) begin
         dlyCnt <= dlyCnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: logic/cfgRegs.sv
`default_nettype none

module cfgRegs import memUnitPkg::*; #(
   parameter int addrW = 10
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  logic      cfgWrite,
   input  logic      cfgPort,
   input  cfgField_t cfgField,
   input  addr_t     cfgData,
   memCfgIf.source   cfgA,
   memCfgIf.source   cfgB
);

   // one word per field, index 0 is port A
   logic [addrW-1:0] shadow [2][CfgFields];
   logic [addrW-1:0] active [2][CfgFields];

   // clip a written value to the width of its field
   function automatic logic [addrW-1:0] truncField(cfgField_t f, logic [addrW-1:0] d);
      logic [addrW-1:0] r;
      case (f)
         fldPer, fldDuty, fldDelay: r = d & addrW'((1 << PeriodW) - 1);
         fldReverse, fldExt, fldWrEn: r = addrW'(d[0]);
         default: r = d;
      endcase
      return r;
   endfunction

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         shadow <= '{default: '0};
         active <= '{default: '0};
      end else begin
         if (cfgWrite && cfgField < CfgFields) begin
            shadow[cfgPort][cfgField] <= truncField(cfgField, cfgData);
         end
         // a write in the run cycle lands in shadow only
         if (run) begin
            active <= shadow;
         end
      end
   end

   assign cfgA.iter    = active[0][fldIter];
   assign cfgA.per     = active[0][fldPer][PeriodW-1:0];
   assign cfgA.duty    = active[0][fldDuty][PeriodW-1:0];
   assign cfgA.start   = active[0][fldStart];
   assign cfgA.shift   = active[0][fldShift];
   assign cfgA.incr    = active[0][fldIncr];
   assign cfgA.delay   = active[0][fldDelay][PeriodW-1:0];
   assign cfgA.reverse = active[0][fldReverse][0];
   assign cfgA.ext     = active[0][fldExt][0];
   assign cfgA.wrEn    = active[0][fldWrEn][0];
   assign cfgA.iter2   = active[0][fldIter2];
   assign cfgA.shift2  = active[0][fldShift2];

   assign cfgB.iter    = active[1][fldIter];
   assign cfgB.per     = active[1][fldPer][PeriodW-1:0];
   assign cfgB.duty    = active[1][fldDuty][PeriodW-1:0];
   assign cfgB.start   = active[1][fldStart];
   assign cfgB.shift   = active[1][fldShift];
   assign cfgB.incr    = active[1][fldIncr];
   assign cfgB.delay   = active[1][fldDelay][PeriodW-1:0];
   assign cfgB.reverse = active[1][fldReverse][0];
   assign cfgB.ext     = active[1][fldExt][0];
   assign cfgB.wrEn    = active[1][fldWrEn][0];
   assign cfgB.iter2   = active[1][fldIter2];
   assign cfgB.shift2  = active[1][fldShift2];

endmodule

`default_nettype wire

// File: logic/memPortIf.sv
`default_nettype none

interface memPortIf #(
   parameter int addrW = 10,
   parameter int dataW = 32
) ();

   logic             en;
   logic             we;
   logic [addrW-1:0] addr;
   logic [dataW-1:0] wdata;
   logic [dataW-1:0] rdata;

   modport controller (
      output en, we, addr, wdata,
      input  rdata
   );

   modport ram (
      input  en, we, addr, wdata,
      output rdata
   );

endinterface

`default_nettype wire

// File: logic/memCfgIf.sv
`default_nettype none

interface memCfgIf import memUnitPkg::*; ();

   // loop fields
   addr_t   iter;
   period_t per;
   period_t duty;
   addr_t   start;
   addr_t   shift;
   addr_t   incr;
   period_t delay;

   // port mode bits
   logic    reverse;
   logic    ext;
   logic    wrEn;

   // outer loop
   addr_t   iter2;
   addr_t   shift2;

   modport source (
      output iter, per, duty, start, shift, incr, delay,
      output reverse, ext, wrEn, iter2, shift2
   );

   modport sink (
      input iter, per, duty, start, shift, incr, delay,
      input reverse, ext, wrEn, iter2, shift2
   );

endinterface

`default_nettype wire

// File: logic/memUnitPkg.sv
`default_nettype none

package memUnitPkg;

   // default widths, the top level passes its own down as parameters
   localparam int AddrW = 10;
   localparam int DataW = 32;
   localparam int PeriodW = 5;

   // number of config fields per port
   localparam int CfgFields = 12;

   typedef logic [DataW-1:0] data_t;
   typedef logic [AddrW-1:0] addr_t;
   typedef logic [PeriodW-1:0] period_t;
   typedef logic [3:0] cfgField_t;

   // config field indices as seen on cfgField
   localparam cfgField_t fldIter = 4'd0;
   localparam cfgField_t fldPer = 4'd1;
   localparam cfgField_t fldDuty = 4'd2;
   localparam cfgField_t fldStart = 4'd3;
   localparam cfgField_t fldShift = 4'd4;
   localparam cfgField_t fldIncr = 4'd5;
   localparam cfgField_t fldDelay = 4'd6;
   localparam cfgField_t fldReverse = 4'd7;
   localparam cfgField_t fldExt = 4'd8;
   localparam cfgField_t fldWrEn = 4'd9;
   localparam cfgField_t fldIter2 = 4'd10;
   localparam cfgField_t fldShift2 = 4'd11;

   typedef enum logic [1:0] {
      stIdle,
      stDelay,
      stRun
   } genState_t;

endpackage

`default_nettype wire
